// ==== Makefile ====
SIM      = verilator
TOP      = tb_mem1r1w
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES  = $(wildcard rtl/*.sv) $(wildcard rtl/*.svh) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/bank_arbiter.sv ====
`timescale 1ns/1ps

`include "mem1r1w_config.svh"

module bank_arbiter (
  input  mem1r1w_pkg::mem_req_t   wr_req,
  input  mem1r1w_pkg::data_t      wdata,
  input  mem1r1w_pkg::mem_req_t   rd_req,
  input  mem1r1w_pkg::map_entry_t wr_entry,
  input  mem1r1w_pkg::data_t      wr_cdata,
  output mem1r1w_pkg::bank_cmd_t  bank_cmd [`MEM_NUM_BANK],
  output mem1r1w_pkg::map_wr_t    map_wr
);

  import mem1r1w_pkg::*;

  steer_e                   steer;
  logic                     old_to_home;
  logic                     old_to_clear;
  logic [`MEM_NUM_BANK-1:0] rd_sel;
  logic [`MEM_NUM_BANK-1:0] home_sel;
  logic [`MEM_NUM_BANK-1:0] wb_sel;

  // the read owns its bank, a colliding write goes to the cache
  always_comb begin
    if (!wr_req.vld) begin
      steer = STEER_IDLE;
    end else if (rd_req.vld && (rd_req.bank == wr_req.bank)) begin
      steer = STEER_CACHE;
    end else begin
      steer = STEER_HOME;
    end
  end

  // displaced word of another bank goes back home
  assign old_to_home = (steer == STEER_CACHE) && wr_entry.cached &&
                       (wr_entry.bank != wr_req.bank);

  // home write makes the cached copy of the same bank stale
  assign old_to_clear = (steer == STEER_HOME) && wr_entry.cached &&
                        (wr_entry.bank == wr_req.bank);

  always_comb begin
    for (int b = 0; b < `MEM_NUM_BANK; b++) begin
      rd_sel[b]   = rd_req.vld && (rd_req.bank == bank_t'(b));
      home_sel[b] = (steer == STEER_HOME) && (wr_req.bank == bank_t'(b));
      wb_sel[b]   = old_to_home && (wr_entry.bank == bank_t'(b));
    end
  end

  always_comb begin
    for (int b = 0; b < `MEM_NUM_BANK; b++) begin
      bank_cmd[b].rd    = rd_sel[b];
      bank_cmd[b].wr    = home_sel[b] || wb_sel[b];
      bank_cmd[b].row   = rd_sel[b] ? rd_req.row : wr_req.row;
      bank_cmd[b].wdata = home_sel[b] ? wdata : wr_cdata;
    end
  end

  always_comb begin
    map_wr = '0;
    case (steer)
      STEER_CACHE: begin
        map_wr.en           = 1'b1;
        map_wr.row          = wr_req.row;
        map_wr.entry.cached = 1'b1;
        map_wr.entry.bank   = wr_req.bank;
        map_wr.data         = wdata;
      end
      STEER_HOME: begin
        if (old_to_clear) begin
          map_wr.en  = 1'b1;
          map_wr.row = wr_req.row;
        end
      end
      default: begin
        map_wr = '0;
      end
    endcase
  end

  // steering must never put two accesses on one single-port bank
  always_comb begin
    a_bank_conflict : assert (((rd_sel & (home_sel | wb_sel)) | (home_sel & wb_sel)) == '0)
      else $error("bank_arbiter: two accesses on one bank at %0t", $time);
  end

endmodule

// ==== rtl/home_bank.sv ====
`timescale 1ns/1ps

`include "mem1r1w_config.svh"

module home_bank (
  input  logic                   clk,
  input  mem1r1w_pkg::bank_cmd_t cmd,
  output mem1r1w_pkg::data_t     rdata
);

  import mem1r1w_pkg::*;

  data_t mem [`MEM_NUM_ROW];

  // single port, write lands at the edge
  always_ff @(posedge clk) begin
    if (cmd.wr) begin
      mem[cmd.row] <= cmd.wdata;
    end
  end

  // registered read, output holds between reads
  always_ff @(posedge clk) begin
    if (cmd.rd) begin
      rdata <= mem[cmd.row];
    end
  end

  // one access per cycle on a single-port array
  a_one_access : assert property (
    @(posedge clk) !(cmd.rd && cmd.wr)
  ) else $error("home_bank: read and write in the same cycle at %0t", $time);

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps

`include "mem1r1w_config.svh"

module map_table (
  input  logic                    clk,
  input  logic                    rstvld,
  input  mem1r1w_pkg::row_t       rd_row1,
  input  mem1r1w_pkg::row_t       rd_row2,
  input  mem1r1w_pkg::map_wr_t    map_wr,
  output mem1r1w_pkg::map_entry_t entry1,
  output mem1r1w_pkg::map_entry_t entry2,
  output mem1r1w_pkg::data_t      cdata1,
  output mem1r1w_pkg::data_t      cdata2,
  output logic                    ready
);

  import mem1r1w_pkg::*;

  map_entry_t  entries [`MEM_NUM_ROW];
  data_t       cache [`MEM_NUM_ROW];
  init_state_e state;
  row_t        sweep_row;
  logic        sweeping;

  assign sweeping = (state == INIT_SWEEP);

  // sweep one row per cycle after reset
  always_ff @(posedge clk) begin
    if (rstvld) begin
      state     <= INIT_SWEEP;
      sweep_row <= '0;
    end else begin
      case (state)
        INIT_SWEEP: begin
          sweep_row <= sweep_row + 1'b1;
          if (sweep_row == row_t'(`MEM_NUM_ROW - 1)) begin
            state <= INIT_DONE;
          end
        end
        default: begin
          state <= INIT_DONE;
        end
      endcase
    end
  end

  // entries and cached words
  always_ff @(posedge clk) begin
    if (sweeping) begin
      entries[sweep_row] <= '0;
    end else if (map_wr.en) begin
      entries[map_wr.row] <= map_wr.entry;
      cache[map_wr.row]   <= map_wr.data;
    end
  end

  // port 1 looks up the write row, port 2 the read row
  assign entry1 = entries[rd_row1];
  assign cdata1 = cache[rd_row1];
  assign entry2 = entries[rd_row2];
  assign cdata2 = cache[rd_row2];

  assign ready = (state == INIT_DONE);

  // requests are gated upstream until the sweep is over
  a_no_write_in_sweep : assert property (
    @(posedge clk) disable iff (rstvld)
    sweeping |-> !map_wr.en
  ) else $error("map_table: map write during init sweep at %0t", $time);

endmodule

// ==== rtl/mem1r1w_config.svh ====
`ifndef MEM1R1W_CONFIG_SVH
`define MEM1R1W_CONFIG_SVH

// data word
`define MEM_WIDTH 32

// home banks, upper address bits
`define MEM_NUM_BANK 8
`define MEM_BANK_BITS 3

// rows per bank, lower address bits
`define MEM_NUM_ROW 64
`define MEM_ROW_BITS 6

// logical address is {bank, row}
`define MEM_ADDR_BITS 9

`endif

// ==== rtl/mem1r1w_pkg.sv ====
`include "mem1r1w_config.svh"

package mem1r1w_pkg;

  typedef logic [`MEM_WIDTH-1:0]     data_t;
  typedef logic [`MEM_BANK_BITS-1:0] bank_t;
  typedef logic [`MEM_ROW_BITS-1:0]  row_t;
  typedef logic [`MEM_ADDR_BITS-1:0] addr_t;

  // cache slot of a row holds the word of this bank
  typedef struct packed {
    logic  cached;
    bank_t bank;
  } map_entry_t;

  // one home bank access
  typedef struct packed {
    logic  rd;
    logic  wr;
    row_t  row;
    data_t wdata;
  } bank_cmd_t;

  // one map entry and cached word update
  typedef struct packed {
    logic       en;
    row_t       row;
    map_entry_t entry;
    data_t      data;
  } map_wr_t;

  typedef struct packed {
    logic  vld;
    bank_t bank;
    row_t  row;
  } mem_req_t;

  typedef enum logic [1:0] {
    STEER_IDLE,
    STEER_HOME,
    STEER_CACHE
  } steer_e;

  typedef enum logic {
    INIT_SWEEP,
    INIT_DONE
  } init_state_e;

endpackage

// ==== rtl/mem1r1w_top.sv ====
`timescale 1ns/1ps

`include "mem1r1w_config.svh"

module mem1r1w_top (
  input  logic               clk,
  input  logic               rstvld,
  input  logic               vwrite,
  input  mem1r1w_pkg::addr_t vwraddr,
  input  mem1r1w_pkg::data_t vdin,
  input  logic               vread,
  input  mem1r1w_pkg::addr_t vrdaddr,
  output logic               vread_vld,
  output mem1r1w_pkg::data_t vdout,
  output logic               ready
);

  import mem1r1w_pkg::*;

  mem_req_t   wr_req;
  mem_req_t   rd_req;
  map_entry_t wr_entry;
  map_entry_t rd_entry;
  data_t      wr_cdata;
  data_t      rd_cdata;
  map_wr_t    map_wr;
  bank_cmd_t  bank_cmd [`MEM_NUM_BANK];
  data_t      bank_rdata [`MEM_NUM_BANK];
  bank_t      rd_bank;
  data_t      sel_rdata;

  // requests only count once the map table is swept
  assign wr_req.vld  = vwrite && ready;
  assign wr_req.bank = vwraddr[`MEM_ADDR_BITS-1:`MEM_ROW_BITS];
  assign wr_req.row  = vwraddr[`MEM_ROW_BITS-1:0];

  assign rd_req.vld  = vread && ready;
  assign rd_req.bank = vrdaddr[`MEM_ADDR_BITS-1:`MEM_ROW_BITS];
  assign rd_req.row  = vrdaddr[`MEM_ROW_BITS-1:0];

  map_table u_map_table (
    .clk     (clk),
    .rstvld  (rstvld),
    .rd_row1 (wr_req.row),
    .rd_row2 (rd_req.row),
    .map_wr  (map_wr),
    .entry1  (wr_entry),
    .entry2  (rd_entry),
    .cdata1  (wr_cdata),
    .cdata2  (rd_cdata),
    .ready   (ready)
  );

  bank_arbiter u_bank_arbiter (
    .wr_req   (wr_req),
    .wdata    (vdin),
    .rd_req   (rd_req),
    .wr_entry (wr_entry),
    .wr_cdata (wr_cdata),
    .bank_cmd (bank_cmd),
    .map_wr   (map_wr)
  );

  for (genvar b = 0; b < `MEM_NUM_BANK; b++) begin : g_bank
    home_bank u_home_bank (
      .clk   (clk),
      .cmd   (bank_cmd[b]),
      .rdata (bank_rdata[b])
    );
  end

  // data of the bank read in the previous cycle
  assign sel_rdata = bank_rdata[rd_bank];

  read_path u_read_path (
    .clk        (clk),
    .rstvld     (rstvld),
    .rd_req     (rd_req),
    .entry      (rd_entry),
    .cdata      (rd_cdata),
    .bank_rdata (sel_rdata),
    .rd_bank    (rd_bank),
    .vread_vld  (vread_vld),
    .vdout      (vdout)
  );

endmodule

// ==== rtl/read_path.sv ====
`timescale 1ns/1ps

`include "mem1r1w_config.svh"

module read_path (
  input  logic                    clk,
  input  logic                    rstvld,
  input  mem1r1w_pkg::mem_req_t   rd_req,
  input  mem1r1w_pkg::map_entry_t entry,
  input  mem1r1w_pkg::data_t      cdata,
  input  mem1r1w_pkg::data_t      bank_rdata,
  output mem1r1w_pkg::bank_t      rd_bank,
  output logic                    vread_vld,
  output mem1r1w_pkg::data_t      vdout
);

  import mem1r1w_pkg::*;

  logic  vld_q;
  logic  hit_q;
  bank_t bank_q;
  data_t cdata_q;
  logic  hit;

  // the cache holds the requested word
  assign hit = entry.cached && (entry.bank == rd_req.bank);

  always_ff @(posedge clk) begin
    if (rstvld) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_req.vld;
    end
  end

  // lookup captured with the bank read, before this cycle's write lands
  always_ff @(posedge clk) begin
    if (rd_req.vld) begin
      hit_q   <= hit;
      bank_q  <= rd_req.bank;
      cdata_q <= cdata;
    end
  end

  assign rd_bank   = bank_q;
  assign vread_vld = vld_q;
  assign vdout     = hit_q ? cdata_q : bank_rdata;

endmodule

// ==== sim/tb_mem1r1w.sv ====
`timescale 1ns/1ps

`include "mem1r1w_config.svh"

module tb_mem1r1w;

  import mem1r1w_pkg::*;

  localparam int NUM_WORDS   = `MEM_NUM_BANK * `MEM_NUM_ROW;
  localparam int RAND_CYCLES = 3000;
  localparam int READY_LIMIT = `MEM_NUM_ROW + 4;

  logic  clk;
  logic  rstvld;
  logic  vwrite;
  addr_t vwraddr;
  data_t vdin;
  logic  vread;
  addr_t vrdaddr;
  logic  vread_vld;
  data_t vdout;
  logic  ready;

  data_t       model [NUM_WORDS];
  data_t       rd_exp;
  data_t       exp_q;
  logic        rd_acc;
  addr_t       junk_q [$];
  logic [31:0] seed = 32'hf326_2152;
  bit          timed_out = 1'b0;
  int          sweep_cnt = 0;
  int          n_reads = 0;
  int          err_data = 0;
  int          err_vld = 0;
  int          err_stray = 0;
  int          err_rst_vld = 0;
  int          err_ready_time = 0;
  int          err_ready_stay = 0;
  int          err_sweep = 0;

  mem1r1w_top u_mem1r1w_top (
    .clk       (clk),
    .rstvld    (rstvld),
    .vwrite    (vwrite),
    .vwraddr   (vwraddr),
    .vdin      (vdin),
    .vread     (vread),
    .vrdaddr   (vrdaddr),
    .vread_vld (vread_vld),
    .vdout     (vdout),
    .ready     (ready)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // reference model, read value taken before this cycle's write
  assign rd_acc = vread && ready;
  assign rd_exp = model[vrdaddr];

  always @(posedge clk) begin
    if (vwrite && ready) begin
      model[vwraddr] <= vdin;
    end
    exp_q <= rd_exp;
  end

  always @(posedge clk) begin
    if (rstvld) begin
      sweep_cnt <= 0;
    end else if (!ready) begin
      sweep_cnt <= sweep_cnt + 1;
    end
    if (!rstvld && rd_acc) begin
      n_reads <= n_reads + 1;
    end
  end

  a_read_vld : assert property (
    @(posedge clk) disable iff (rstvld) rd_acc |=> vread_vld
  ) else begin
    err_vld++;
    $display("Error at time %0t: no vread_vld one cycle after a read", $time);
  end

  a_read_data : assert property (
    @(posedge clk) disable iff (rstvld) rd_acc |=> (vdout == exp_q)
  ) else begin
    err_data++;
    $display("Error at time %0t: vdout %h, expected %h", $time, $sampled(vdout),
             $sampled(exp_q));
  end

  a_no_stray_vld : assert property (
    @(posedge clk) disable iff (rstvld) !rd_acc |=> !vread_vld
  ) else begin
    err_stray++;
    $display("Error at time %0t: vread_vld without an accepted read", $time);
  end

  a_reset_vld : assert property (
    @(posedge clk) rstvld |=> !vread_vld
  ) else begin
    err_rst_vld++;
    $display("Error at time %0t: vread_vld high after a reset cycle", $time);
  end

  // sweep length is one cycle per row
  a_ready_time : assert property (
    @(posedge clk) disable iff (rstvld)
    $rose(ready) |-> (sweep_cnt >= `MEM_NUM_ROW && sweep_cnt <= READY_LIMIT)
  ) else begin
    err_ready_time++;
    $display("Error at time %0t: ready rose after %0d cycles", $time, $sampled(sweep_cnt));
  end

  a_sweep_bound : assert property (
    @(posedge clk) disable iff (rstvld) sweep_cnt <= READY_LIMIT
  ) else begin
    err_sweep++;
    $display("Error at time %0t: ready still low after %0d cycles", $time, $sampled(sweep_cnt));
  end

  a_ready_stays : assert property (
    @(posedge clk) disable iff (rstvld) ready |=> ready
  ) else begin
    err_ready_stay++;
    $display("Error at time %0t: ready fell outside reset", $time);
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic data_t fill_value(input addr_t a);
    return {7'h5a, a, 7'h13, a};
  endfunction

  task automatic next_rand(output logic [31:0] r);
    seed = lcg_next(seed);
    r = seed;
  endtask

  task automatic drive(input logic wr, input addr_t waddr, input data_t wdata,
                       input logic rd, input addr_t raddr);
    @(posedge clk);
    vwrite  <= wr;
    vwraddr <= waddr;
    vdin    <= wdata;
    vread   <= rd;
    vrdaddr <= raddr;
  endtask

  task automatic idle();
    drive(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic run_reset();
    @(posedge clk);
    rstvld <= 1'b1;
    repeat (10) @(posedge clk);
    rstvld <= 1'b0;
  endtask

  // optionally hammers the DUT with requests while the sweep runs
  task automatic wait_ready(input bit junk);
    logic [31:0] r;
    int          cnt;
    cnt = 0;
    while (!ready && !timed_out) begin
      if (cnt == READY_LIMIT + 8) begin
        timed_out = 1'b1;
        $display("timeout: ready did not rise within %0d cycles of reset", cnt);
      end else begin
        if (junk) begin
          next_rand(r);
          junk_q.push_back(addr_t'(r[31:23]));
          drive(1'b1, addr_t'(r[31:23]), ~r, 1'b1, addr_t'(r[22:14]));
        end else begin
          @(posedge clk);
        end
        cnt++;
      end
    end
    idle();
  endtask

  task automatic fill_memory();
    for (int a = 0; a < NUM_WORDS; a++) begin
      drive(1'b1, addr_t'(a), fill_value(addr_t'(a)), 1'b0, '0);
    end
    idle();
  endtask

  task automatic read_back_junk();
    while (junk_q.size() > 0) begin
      drive(1'b0, '0, '0, 1'b1, junk_q.pop_front());
    end
    idle();
  endtask

  task automatic directed_tests();
    // same bank, different rows
    drive(1'b1, {3'd2, 6'd5}, 32'hc0de_0001, 1'b1, {3'd2, 6'd9});
    drive(1'b0, '0, '0, 1'b1, {3'd2, 6'd5});
    // each write displaces the previous bank's word from row 7
    for (int b = 0; b < 4; b++) begin
      drive(1'b1, {3'(b), 6'd7}, 32'hcafe_0000 + b, 1'b1, {3'(b), 6'd20});
    end
    for (int b = 0; b < 4; b++) begin
      drive(1'b0, '0, '0, 1'b1, {3'(b), 6'd7});
    end
    // home write over a cached word clears the entry
    drive(1'b1, {3'd3, 6'd7}, 32'hbeef_0003, 1'b1, {3'd6, 6'd1});
    drive(1'b0, '0, '0, 1'b1, {3'd3, 6'd7});
    // same address in one cycle
    drive(1'b1, {3'd5, 6'd33}, 32'h1234_5678, 1'b1, {3'd5, 6'd33});
    drive(1'b0, '0, '0, 1'b1, {3'd5, 6'd33});
    idle();
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    logic [31:0] d;
    addr_t       waddr;
    addr_t       raddr;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      next_rand(r);
      next_rand(d);
      // half the rows from a set of four, so collisions are common
      waddr = {r[27:25], r[24] ? r[23:18] : {4'd0, r[19:18]}};
      raddr = {r[17:15], r[14] ? r[13:8] : {4'd0, r[9:8]}};
      drive(r[31] | r[30], waddr, d, r[29] | r[28], raddr);
    end
    idle();
  endtask

  // last answers must be checked before the report
  task automatic drain();
    int cnt;
    int quiet;
    cnt = 0;
    quiet = 0;
    while (quiet < 2 && !timed_out) begin
      if (cnt == 16) begin
        timed_out = 1'b1;
        $display("timeout: vread_vld did not settle low at the end of traffic");
      end else begin
        @(posedge clk);
        quiet = vread_vld ? 0 : quiet + 1;
        cnt++;
      end
    end
  endtask

  initial begin
    int total;
    rstvld  = 1'b1;
    vwrite  = 1'b0;
    vwraddr = '0;
    vdin    = '0;
    vread   = 1'b0;
    vrdaddr = '0;
    run_reset();
    wait_ready(1'b0);
    if (!timed_out) begin
      fill_memory();
      run_reset();
      wait_ready(1'b1);
    end
    if (!timed_out) begin
      read_back_junk();
      directed_tests();
      random_traffic();
      drain();
    end
    total = err_data + err_vld + err_stray + err_rst_vld + err_ready_time +
            err_ready_stay + err_sweep;
    $display("reads %0d, data errors %0d, valid errors %0d, stray valid %0d, ready errors %0d",
             n_reads, err_data, err_vld + err_rst_vld, err_stray,
             err_ready_time + err_ready_stay + err_sweep);
    if (timed_out || total != 0) begin
      $display("=== FAIL ===");
    end else begin
      $display("=== PASS ===");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/mem1r1w_pkg.sv
rtl/home_bank.sv
rtl/map_table.sv
rtl/bank_arbiter.sv
rtl/read_path.sv
rtl/mem1r1w_top.sv
sim/tb_mem1r1w.sv
